// ==== common/vtage_consts.svh ====
// ================================================
// vtage constants
// table geometry, history lengths, suppression window
// ================================================
`ifndef VTAGE_CONSTS_SVH
`define VTAGE_CONSTS_SVH

`define VTAGE_NUM_BANK          4       // bank 0 is the untagged baseline
`define VTAGE_NUM_ENTRIES       256     // entries per bank
`define VTAGE_TAG_WIDTH         5
`define VTAGE_CONF_WIDTH        3
`define VTAGE_GBH_LENGTH        64      // global branch history input width

// cycles without predictions after reset or a mispredict
`define VTAGE_SUPPRESS_CYCLES   128

// history bits folded by bank b: 0, 4, 16, 64
`define VTAGE_HIST_LEN(b)       ((b) == 0 ? 0 : (4 ** (b)))

`endif

// ==== common/vtage_pkg.sv ====
// ================================================
// vtage package
// shared predictor types
// ================================================
`include "vtage_consts.svh"

package vtage_pkg;

    typedef logic [$clog2(`VTAGE_NUM_ENTRIES)-1:0] index_t;
    typedef logic [`VTAGE_TAG_WIDTH-1:0]           tag_t;
    typedef logic [`VTAGE_CONF_WIDTH-1:0]          conf_t;   // saturating
    typedef logic [31:0]                           value_t;
    typedef logic [$clog2(`VTAGE_NUM_BANK)-1:0]    bank_sel_t;
    typedef logic [31:1]                           pc_t;     // halfword aligned
    typedef logic [`VTAGE_GBH_LENGTH-1:0]          gbh_t;

    // one table entry, the value is held in place
    typedef struct packed {
        logic   valid;
        tag_t   tag;
        conf_t  conf;
        value_t value;
    } entry_t;

endpackage

// ==== common/vtage_bank_if.sv ====
// ================================================
// vtage bank interface
// hash, bank, selector and update unit of one bank
// ================================================
`timescale 1ns/10ps

interface vtage_bank_if;

    // lookup side
    vtage_pkg::index_t  lk_index;
    vtage_pkg::tag_t    lk_tag;
    logic               lk_hit;     // registered, one cycle after index
    vtage_pkg::entry_t  lk_entry;

    // feedback side
    vtage_pkg::index_t  fb_index;
    vtage_pkg::tag_t    fb_tag;
    logic               wr_en;      // train the predicting entry
    logic               wr_alloc;   // new entry with zero confidence
    vtage_pkg::conf_t   wr_conf;
    vtage_pkg::value_t  wr_value;

    modport hash (
        output lk_index, lk_tag, fb_index, fb_tag
    );

    modport bank (
        input  lk_index, lk_tag, fb_index, fb_tag,
        input  wr_en, wr_alloc, wr_conf, wr_value,
        output lk_hit, lk_entry
    );

    modport select (
        input  lk_hit, lk_entry
    );

    modport update (
        output wr_en, wr_alloc, wr_conf, wr_value
    );

endinterface

// ==== bank/vtage_bank.sv ====
// ================================================
// vtage bank
// one prediction table, registered lookup, feedback write
// ================================================
`timescale 1ns/10ps
`include "vtage_consts.svh"

module vtage_bank #(
    parameter bit TAGGED = 1'b1     // 0 for the baseline, hits on any valid entry
) (
    input  logic        clk_i,
    input  logic        rst_i,
    vtage_bank_if.bank  port
);

    vtage_pkg::entry_t mem [`VTAGE_NUM_ENTRIES];

    vtage_pkg::entry_t rd_entry;
    logic              rd_match;
    vtage_pkg::entry_t wr_entry;

    // lookup read and tag compare, sampled at the next edge
    assign rd_entry = mem[port.lk_index];
    assign rd_match = rd_entry.valid && (!TAGGED || (rd_entry.tag == port.lk_tag));

    // both write kinds leave a valid entry carrying the feedback tag
    always_comb begin
        wr_entry.valid = 1'b1;
        wr_entry.tag   = port.fb_tag;
        wr_entry.conf  = port.wr_alloc ? '0 : port.wr_conf;     // fresh entry starts unsure
        wr_entry.value = port.wr_value;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `VTAGE_NUM_ENTRIES; i++) begin
                mem[i] <= '0;
            end
        end else if (port.wr_en || port.wr_alloc) begin
            mem[port.fb_index] <= wr_entry;    // lookup at this edge still reads old data
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            port.lk_hit <= 1'b0;
        end else begin
            port.lk_hit <= rd_match;
        end
    end

    always_ff @(posedge clk_i) begin
        port.lk_entry <= rd_entry;  // payload, qualified by lk_hit
    end

    // update unit trains one bank and allocates in another, never both here
    a_no_write_and_alloc: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(port.wr_en && port.wr_alloc)
    );

endmodule

// ==== logic/vtage_hash.sv ====
// ================================================
// vtage hash
// folds pc and truncated history into index and tag
// ================================================
`timescale 1ns/10ps
`include "vtage_consts.svh"

module vtage_hash (
    input  vtage_pkg::pc_t   fw_pc_i,
    input  vtage_pkg::gbh_t  fw_gbh_i,
    input  vtage_pkg::pc_t   fb_pc_i,
    input  vtage_pkg::gbh_t  fb_gbh_i,
    vtage_bank_if.hash       banks [`VTAGE_NUM_BANK]
);

    localparam int IDX_W    = $bits(vtage_pkg::index_t);
    localparam int IDX_SLC  = (`VTAGE_GBH_LENGTH + IDX_W - 1) / IDX_W;
    localparam int IDX_PADW = IDX_SLC * IDX_W;
    localparam int TAG_SLC  = (`VTAGE_GBH_LENGTH + `VTAGE_TAG_WIDTH - 1) / `VTAGE_TAG_WIDTH;
    localparam int TAG_PADW = TAG_SLC * `VTAGE_TAG_WIDTH;

    // xor of consecutive index-wide slices
    function automatic vtage_pkg::index_t fold_index(input logic [IDX_PADW-1:0] v);
        vtage_pkg::index_t acc;
        acc = '0;
        for (int i = 0; i < IDX_SLC; i++) begin
            acc ^= v[i*IDX_W +: IDX_W];
        end
        return acc;
    endfunction

    // same for tag-wide slices, last slice zero padded
    function automatic vtage_pkg::tag_t fold_tag(input logic [TAG_PADW-1:0] v);
        vtage_pkg::tag_t acc;
        acc = '0;
        for (int i = 0; i < TAG_SLC; i++) begin
            acc ^= v[i*`VTAGE_TAG_WIDTH +: `VTAGE_TAG_WIDTH];
        end
        return acc;
    endfunction

    // baseline indexes with the pc directly, no tag
    assign banks[0].lk_index = fw_pc_i[IDX_W:1];
    assign banks[0].lk_tag   = '0;
    assign banks[0].fb_index = fb_pc_i[IDX_W:1];
    assign banks[0].fb_tag   = '0;

    for (genvar b = 1; b < `VTAGE_NUM_BANK; b++) begin : gen_fold
        localparam int HL = `VTAGE_HIST_LEN(b);
        localparam vtage_pkg::gbh_t MASK = {`VTAGE_GBH_LENGTH{1'b1}} >> (`VTAGE_GBH_LENGTH - HL);

        vtage_pkg::gbh_t fw_hist;
        vtage_pkg::gbh_t fb_hist;

        assign fw_hist = fw_gbh_i & MASK;   // truncate to this bank's length
        assign fb_hist = fb_gbh_i & MASK;

        assign banks[b].lk_index = fold_index(IDX_PADW'(fw_hist))
                                 ^ fold_index(IDX_PADW'(fw_pc_i));
        assign banks[b].lk_tag   = fold_tag(TAG_PADW'(fw_hist)) ^ fold_tag(TAG_PADW'(fw_pc_i));
        assign banks[b].fb_index = fold_index(IDX_PADW'(fb_hist))
                                 ^ fold_index(IDX_PADW'(fb_pc_i));
        assign banks[b].fb_tag   = fold_tag(TAG_PADW'(fb_hist)) ^ fold_tag(TAG_PADW'(fb_pc_i));
    end

endmodule

// ==== logic/vtage_select.sv ====
// ================================================
// vtage select
// longest-history hit wins, drives the prediction
// ================================================
`timescale 1ns/10ps
`include "vtage_consts.svh"

module vtage_select (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  fw_valid_i,
    input  logic                  pred_enable_i,
    vtage_bank_if.select          banks [`VTAGE_NUM_BANK],
    output logic                  pred_valid_o,
    output vtage_pkg::value_t     pred_value_o,
    output vtage_pkg::conf_t      pred_conf_o,
    output vtage_pkg::bank_sel_t  pred_bank_o
);

    logic              hit   [`VTAGE_NUM_BANK];
    vtage_pkg::entry_t entry [`VTAGE_NUM_BANK];
    vtage_pkg::bank_sel_t sel;

    for (genvar b = 0; b < `VTAGE_NUM_BANK; b++) begin : gen_drain
        assign hit[b]   = banks[b].lk_hit;
        assign entry[b] = banks[b].lk_entry;
    end

    // priority mux, later banks override
    always_comb begin
        sel = '0;   // baseline by default
        for (int b = 1; b < `VTAGE_NUM_BANK; b++) begin
            if (hit[b]) begin
                sel = vtage_pkg::bank_sel_t'(b);
            end
        end
    end

    assign pred_bank_o  = sel;
    assign pred_value_o = hit[sel] ? entry[sel].value : '0;   // total miss reads as zero
    assign pred_conf_o  = hit[sel] ? entry[sel].conf : '0;

    // valid lines up with the registered bank lookup
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= fw_valid_i && pred_enable_i;
        end
    end

    a_valid_needs_enable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        pred_valid_o |-> $past(pred_enable_i)
    );

endmodule

// ==== logic/vtage_update.sv ====
// ================================================
// vtage update
// confidence training, allocation, mispredict window
// ================================================
`timescale 1ns/10ps
`include "vtage_consts.svh"

module vtage_update (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  fb_valid_i,
    input  vtage_pkg::bank_sel_t  fb_bank_i,
    input  vtage_pkg::conf_t      fb_conf_i,
    input  vtage_pkg::value_t     fb_pred_i,
    input  vtage_pkg::value_t     fb_actual_i,
    output logic                  pred_enable_o,
    vtage_bank_if.update          banks [`VTAGE_NUM_BANK]
);

    localparam int CNT_W = $clog2(`VTAGE_SUPPRESS_CYCLES) + 1;

    logic               mispredict;
    vtage_pkg::conf_t   conf_inc;
    vtage_pkg::conf_t   conf_next;
    logic [CNT_W-1:0]   quiet_cnt;      // cycles since last mispredict
    logic               alloc [`VTAGE_NUM_BANK];

    assign mispredict = fb_valid_i && (fb_actual_i != fb_pred_i);

    // saturating increment
    assign conf_inc  = (fb_conf_i == '1) ? fb_conf_i : fb_conf_i + 1'b1;
    assign conf_next = mispredict ? '0 : conf_inc;

    for (genvar b = 0; b < `VTAGE_NUM_BANK; b++) begin : gen_wr
        assign banks[b].wr_en    = fb_valid_i && (fb_bank_i == vtage_pkg::bank_sel_t'(b));
        assign banks[b].wr_conf  = conf_next;
        assign banks[b].wr_value = fb_actual_i;    // equals the prediction when correct

        if (b == 0) begin : gen_no_alloc
            assign alloc[b] = 1'b0;
        end else begin : gen_alloc
            // climb one bank towards longer history
            assign alloc[b] = mispredict && (fb_bank_i == vtage_pkg::bank_sel_t'(b - 1));
        end
        assign banks[b].wr_alloc = alloc[b];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || mispredict) begin
            quiet_cnt <= '0;
        end else if (!quiet_cnt[CNT_W-1]) begin
            quiet_cnt <= quiet_cnt + 1'b1;     // holds once the top bit is set
        end
    end

    assign pred_enable_o = quiet_cnt[CNT_W-1];

    a_no_alloc_bank0: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !banks[0].wr_alloc
    );

endmodule

// ==== logic/vtage_top.sv ====
// ================================================
// vtage top
// single-way VTAGE value predictor, four banks
// ================================================
`timescale 1ns/10ps
`include "vtage_consts.svh"

module vtage_top (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // lookup request
    input  logic                  fw_valid_i,
    input  vtage_pkg::pc_t        fw_pc_i,
    input  vtage_pkg::gbh_t       fw_gbh_i,

    // prediction, one cycle after the request
    output logic                  pred_valid_o,
    output vtage_pkg::value_t     pred_value_o,
    output vtage_pkg::conf_t      pred_conf_o,
    output vtage_pkg::bank_sel_t  pred_bank_o,

    // feedback from execution
    input  logic                  fb_valid_i,
    input  vtage_pkg::pc_t        fb_pc_i,
    input  vtage_pkg::gbh_t       fb_gbh_i,
    input  vtage_pkg::bank_sel_t  fb_bank_i,
    input  vtage_pkg::conf_t      fb_conf_i,
    input  vtage_pkg::value_t     fb_pred_i,
    input  vtage_pkg::value_t     fb_actual_i
);

    logic pred_enable;  // suppression window expired

    vtage_bank_if bank_if [`VTAGE_NUM_BANK] ();

    vtage_hash i_hash (
        .fw_pc_i    (fw_pc_i),
        .fw_gbh_i   (fw_gbh_i),
        .fb_pc_i    (fb_pc_i),
        .fb_gbh_i   (fb_gbh_i),
        .banks      (bank_if)
    );

    for (genvar b = 0; b < `VTAGE_NUM_BANK; b++) begin : gen_bank
        vtage_bank #(
            .TAGGED (b != 0)    // baseline bank has no tag
        ) i_bank (
            .clk_i  (clk_i),
            .rst_i  (rst_i),
            .port   (bank_if[b])
        );
    end

    vtage_select i_select (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fw_valid_i     (fw_valid_i),
        .pred_enable_i  (pred_enable),
        .banks          (bank_if),
        .pred_valid_o   (pred_valid_o),
        .pred_value_o   (pred_value_o),
        .pred_conf_o    (pred_conf_o),
        .pred_bank_o    (pred_bank_o)
    );

    vtage_update i_update (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fb_valid_i     (fb_valid_i),
        .fb_bank_i      (fb_bank_i),
        .fb_conf_i      (fb_conf_i),
        .fb_pred_i      (fb_pred_i),
        .fb_actual_i    (fb_actual_i),
        .pred_enable_o  (pred_enable),
        .banks          (bank_if)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
// ================================================
// testbench clock and reset
// 4 ns clock, reset held for three cycles
// ================================================
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        rst_o <= 1'b0;  // released at the third edge
    end

endmodule

// ==== tb/vtage_tb.sv ====
// ================================================
// vtage testbench
// shadow tables, directed and random lookups, assertion checks
// ================================================
`timescale 1ns/10ps

module vtage_tb;

    logic clk_i;
    logic rst_i;

    logic                  fw_valid_i;
    vtage_pkg::pc_t        fw_pc_i;
    vtage_pkg::gbh_t       fw_gbh_i;
    logic                  pred_valid_o;
    vtage_pkg::value_t     pred_value_o;
    vtage_pkg::conf_t      pred_conf_o;
    vtage_pkg::bank_sel_t  pred_bank_o;
    logic                  fb_valid_i;
    vtage_pkg::pc_t        fb_pc_i;
    vtage_pkg::gbh_t       fb_gbh_i;
    vtage_pkg::bank_sel_t  fb_bank_i;
    vtage_pkg::conf_t      fb_conf_i;
    vtage_pkg::value_t     fb_pred_i;
    vtage_pkg::value_t     fb_actual_i;

    // shadow tables
    logic        m_valid [4][256];
    logic [4:0]  m_tag   [4][256];
    logic [2:0]  m_conf  [4][256];
    logic [31:0] m_value [4][256];

    logic [8:0]  quiet;         // cycles since reset or mispredict
    logic        model_en;
    logic        chk;           // a lookup is driven this cycle
    logic [1:0]  exp_bank;
    logic [2:0]  exp_conf;
    logic [31:0] exp_value;
    logic [1:0]  lp_bank;       // last prediction of the model
    logic [2:0]  lp_conf;
    logic [31:0] lp_value;
    int          err_cnt;

    tb_clock_gen i_clk (.clk_o(clk_i), .rst_o(rst_i));

    vtage_top i_dut (.*);

    assign model_en = (quiet >= 9'd128);

    always @(posedge clk_i) begin
        if (rst_i || (fb_valid_i && fb_actual_i != fb_pred_i)) begin
            quiet <= '0;
        end else if (quiet < 9'd128) begin
            quiet <= quiet + 1'b1;
        end
    end

    // index bit i collects every operand bit at position i mod 8, tag the same mod 5
    function automatic void fold(input int b, input logic [31:1] pc, input logic [63:0] gbh,
                                 output logic [7:0] idx, output logic [4:0] tg);
        int hl;
        idx = '0;
        tg  = '0;
        hl  = (b == 1) ? 4 : (b == 2) ? 16 : 64;
        if (b == 0) begin
            idx = pc[8:1];
        end else begin
            for (int j = 0; j < hl; j++) begin
                idx[j % 8] ^= gbh[j];
                tg[j % 5]  ^= gbh[j];
            end
            for (int j = 0; j < 31; j++) begin
                idx[j % 8] ^= pc[j+1];
                tg[j % 5]  ^= pc[j+1];
            end
        end
    endfunction

    a_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        pred_valid_o == $past(fw_valid_i && model_en))
    else begin
        err_cnt++;
        $display("Fail at %0t: pred_valid_o is %b", $time, pred_valid_o);
        $display("Errors found");
        $fatal(1, "prediction valid mismatch");
    end

    a_pred: assert property (@(posedge clk_i) disable iff (rst_i)
        $past(chk) |-> (pred_bank_o == $past(exp_bank) && pred_conf_o == $past(exp_conf)
                        && pred_value_o == $past(exp_value)))
    else begin
        err_cnt++;
        $display("Fail at %0t: got bank %0d conf %0d value %h", $time,
                 pred_bank_o, pred_conf_o, pred_value_o);
        $display("Errors found");
        $fatal(1, "prediction payload mismatch");
    end

    task automatic lookup(input logic [31:1] pc, input logic [63:0] gbh);
        logic [7:0] idx;
        logic [4:0] tg;
        logic       hit [4];
        int         sel;
        sel = 0;
        for (int b = 0; b < 4; b++) begin
            fold(b, pc, gbh, idx, tg);
            hit[b] = m_valid[b][idx] && (b == 0 || m_tag[b][idx] == tg);
            if (hit[b]) sel = b;
        end
        fold(sel, pc, gbh, idx, tg);
        exp_bank  = 2'(sel);
        exp_conf  = hit[sel] ? m_conf[sel][idx] : '0;
        exp_value = hit[sel] ? m_value[sel][idx] : '0;
        lp_bank   = exp_bank;
        lp_conf   = exp_conf;
        lp_value  = exp_value;
        fw_valid_i = 1'b1;
        fw_pc_i    = pc;
        fw_gbh_i   = gbh;
        chk        = 1'b1;
        @(negedge clk_i);
        fw_valid_i = 1'b0;
        chk        = 1'b0;
    endtask

    task automatic feedback(input logic [31:1] pc, input logic [63:0] gbh, input logic [1:0] bank,
                            input logic [2:0] conf, input logic [31:0] pred,
                            input logic [31:0] actual);
        logic [7:0] idx;
        logic [4:0] tg;
        fold(bank, pc, gbh, idx, tg);
        m_valid[bank][idx] = 1'b1;
        m_tag[bank][idx]   = tg;
        m_value[bank][idx] = actual;
        m_conf[bank][idx]  = (actual != pred) ? 3'd0 : (conf == 3'd7) ? 3'd7 : conf + 3'd1;
        if (actual != pred && bank < 3) begin    // allocate one bank up
            fold(bank + 1, pc, gbh, idx, tg);
            m_valid[bank+1][idx] = 1'b1;
            m_tag[bank+1][idx]   = tg;
            m_conf[bank+1][idx]  = 3'd0;
            m_value[bank+1][idx] = actual;
        end
        fb_valid_i  = 1'b1;
        fb_pc_i     = pc;
        fb_gbh_i    = gbh;
        fb_bank_i   = bank;
        fb_conf_i   = conf;
        fb_pred_i   = pred;
        fb_actual_i = actual;
        @(negedge clk_i);
        fb_valid_i = 1'b0;
    endtask

    // keeps looking up while predictions are suppressed
    task automatic lookup_until_enabled(input logic [31:1] pc, input logic [63:0] gbh);
        int n;
        n = 0;
        while (!model_en) begin
            if (n >= 300) begin
                $display("timeout waiting for the suppression window to end");
                $display("Errors found");
                $fatal(1, "timeout");
            end
            lookup(pc, gbh);
            n++;
        end
    endtask

    initial begin
        logic [31:1] pc0;
        logic [63:0] g0;
        int          n;
        void'($urandom(32'h4ebc_77cf));
        fw_valid_i  = 1'b0;
        fw_pc_i     = '0;
        fw_gbh_i    = '0;
        fb_valid_i  = 1'b0;
        fb_pc_i     = '0;
        fb_gbh_i    = '0;
        fb_bank_i   = '0;
        fb_conf_i   = '0;
        fb_pred_i   = '0;
        fb_actual_i = '0;
        chk = 1'b0;
        exp_bank = '0;
        exp_conf = '0;
        exp_value = '0;
        err_cnt = 0;
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 256; i++) begin
                m_valid[b][i] = 1'b0;
                m_tag[b][i]   = '0;
                m_conf[b][i]  = '0;
                m_value[b][i] = '0;
            end
        end
        pc0 = 31'h1234_5a7;
        g0  = 64'h0123_4567_89ab_cdef;

        @(negedge clk_i);   // reset is asserted by now
        n = 0;
        while (rst_i) begin
            if (n >= 20) begin
                $display("timeout waiting for reset release");
                $display("Errors found");
                $fatal(1, "timeout");
            end
            @(negedge clk_i);
            n++;
        end

        lookup_until_enabled(31'($urandom), 64'($urandom));    // window after reset
        lookup(pc0, g0);                                        // empty tables, bank 0

        repeat (9) begin    // confidence climbs and saturates
            feedback(pc0, g0, lp_bank, lp_conf, lp_value, lp_value);
            lookup(pc0, g0);
        end

        // mispredicts climb to bank 3, then rewrite bank 3 in place
        repeat (4) begin
            feedback(pc0, g0, lp_bank, lp_conf, lp_value, lp_value + 1 + ($urandom % 1000));
            lookup(pc0, g0);
            lookup_until_enabled(pc0, g0);
            lookup(pc0, g0);
        end

        repeat (30) lookup(pc0, {$urandom, $urandom});
        repeat (30) lookup(31'($urandom), {$urandom, $urandom});
        lookup(pc0, g0);
        @(negedge clk_i);
        @(negedge clk_i);

        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vtage_top.f ====
+incdir+common
common/vtage_pkg.sv
common/vtage_bank_if.sv
bank/vtage_bank.sv
logic/vtage_hash.sv
logic/vtage_select.sv
logic/vtage_update.sv
logic/vtage_top.sv
tb/tb_clock_gen.sv
tb/vtage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vtage_tb
FLIST     ?= vtage_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

SRCS := $(wildcard common/*.sv common/*.svh bank/*.sv logic/*.sv tb/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
